// File: act_pkg.sv
`default_nettype none

package act_pkg;

    // Lane geometry of one result vector
    localparam int LANES  = 4;
    localparam int DWIDTH = 8;
    localparam int WORD_W = LANES * DWIDTH;

    // Scratchpad geometry
    localparam int ADDR_W = 6;
    localparam int DEPTH  = 1 << ADDR_W;

    // Vector count of one engine run, 1 to 63
    localparam int CNT_W = 6;

    // Activation type codes
    localparam logic ACT_RELU = 1'b0;
    localparam logic ACT_TANH = 1'b1;

endpackage

`default_nettype wire

// File: act_scratchpad.sv
`default_nettype none
`timescale 1ns/1ps

module act_scratchpad (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [act_pkg::ADDR_W-1:0] addr,
    input  logic [act_pkg::WORD_W-1:0] wdata,
    output logic [act_pkg::WORD_W-1:0] rdata
);

    logic [act_pkg::WORD_W-1:0] mem [act_pkg::DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, data is valid one cycle after the access
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: act_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module act_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    // Host side
    input  logic                       host_req,
    input  logic                       host_we,
    input  logic [act_pkg::ADDR_W-1:0] host_addr,
    input  logic [act_pkg::WORD_W-1:0] host_wdata,
    output logic                       host_gnt,
    output logic                       host_rvalid,
    output logic [act_pkg::WORD_W-1:0] host_rdata,

    // Engine side
    input  logic                       eng_req,
    input  logic                       eng_we,
    input  logic [act_pkg::ADDR_W-1:0] eng_addr,
    input  logic [act_pkg::WORD_W-1:0] eng_wdata,
    output logic                       eng_gnt,
    output logic                       eng_rvalid,
    output logic [act_pkg::WORD_W-1:0] eng_rdata,

    // Scratchpad side
    output logic                       mem_en,
    output logic                       mem_we,
    output logic [act_pkg::ADDR_W-1:0] mem_addr,
    output logic [act_pkg::WORD_W-1:0] mem_wdata,
    input  logic [act_pkg::WORD_W-1:0] mem_rdata
);

    // Set when the engine won the most recent grant
    logic last_eng;

    // Read owner for the data coming back next cycle
    logic rd_host;
    logic rd_eng;

    // Host wins alone, or on a tie when the engine went last
    assign host_gnt = host_req && (!eng_req || last_eng);
    assign eng_gnt  = eng_req && !host_gnt;

    assign mem_en    = host_gnt || eng_gnt;
    assign mem_we    = host_gnt ? host_we    : (eng_gnt && eng_we);
    assign mem_addr  = host_gnt ? host_addr  : eng_addr;
    assign mem_wdata = host_gnt ? host_wdata : eng_wdata;

    // Starts out as if the engine went last, so the host is first
    always_ff @(posedge clk) begin
        if (rst) begin
            last_eng <= 1'b1;
        end else if (host_gnt) begin
            last_eng <= 1'b0;
        end else if (eng_gnt) begin
            last_eng <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_host <= 1'b0;
            rd_eng  <= 1'b0;
        end else begin
            rd_host <= host_gnt && !host_we;
            rd_eng  <= eng_gnt && !eng_we;
        end
    end

    assign host_rvalid = rd_host;
    assign eng_rvalid  = rd_eng;

    // Steer read data only to the side that owns it
    assign host_rdata = rd_host ? mem_rdata : '0;
    assign eng_rdata  = rd_eng  ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: activation.sv
`default_nettype none
`timescale 1ns/1ps

module activation (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       act_type,
    input  logic                       act_enable,
    input  logic                       in_valid,
    input  logic [act_pkg::WORD_W-1:0] in_data,
    output logic                       out_valid,
    output logic [act_pkg::WORD_W-1:0] out_data
);

    // Region index of a signed lane in the piecewise tanh curve
    function automatic logic [3:0] tanh_region(input logic signed [act_pkg::DWIDTH-1:0] x);
        if (x >= 90) begin
            return 4'd0;
        end else if (x >= 39) begin
            return 4'd1;
        end else if (x >= 28) begin
            return 4'd2;
        end else if (x >= 16) begin
            return 4'd3;
        end else if (x >= 1) begin
            return 4'd4;
        end else if (x == 0) begin
            return 4'd5;
        end else if (x >= -15) begin
            return 4'd6;
        end else if (x >= -27) begin
            return 4'd7;
        end else if (x >= -38) begin
            return 4'd8;
        end else if (x >= -89) begin
            return 4'd9;
        end
        return 4'd10;
    endfunction

    logic [3:0]                 lane_region [act_pkg::LANES];
    logic [act_pkg::WORD_W-1:0] relu_d;
    logic [act_pkg::WORD_W-1:0] slope_x_d;
    logic [act_pkg::WORD_W-1:0] icpt_d;

    logic [act_pkg::WORD_W-1:0] relu_q;
    logic [act_pkg::WORD_W-1:0] slope_x_q;
    logic [act_pkg::WORD_W-1:0] icpt_q;
    logic [act_pkg::WORD_W-1:0] tanh_q;

    // Valid pipeline, one stage per register level
    logic valid_s1;
    logic valid_s2;

    always_comb begin
        for (int i = 0; i < act_pkg::LANES; i++) begin
            lane_region[i] = tanh_region(in_data[i*act_pkg::DWIDTH +: act_pkg::DWIDTH]);
        end
    end

    // Per-lane ReLU, slope product and intercept lookup
    always_comb begin
        for (int i = 0; i < act_pkg::LANES; i++) begin
            relu_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] =
                in_data[(i+1)*act_pkg::DWIDTH-1] ? '0 : in_data[i*act_pkg::DWIDTH +: act_pkg::DWIDTH];
            case (lane_region[i])
                4'd2, 4'd8: slope_x_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] =
                    in_data[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] * 8'd2;
                4'd3, 4'd7: slope_x_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] =
                    in_data[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] * 8'd3;
                4'd4, 4'd6: slope_x_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] =
                    in_data[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] * 8'd4;
                default:    slope_x_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = '0;
            endcase
            case (lane_region[i])
                4'd0:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = 8'd127;
                4'd1:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = 8'd99;
                4'd2:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = 8'd46;
                4'd3:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = 8'd18;
                4'd7:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = -8'sd18;
                4'd8:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = -8'sd46;
                4'd9:    icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = -8'sd99;
                4'd10:   icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = -8'sd127;
                default: icpt_d[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            valid_s2 <= valid_s1;
        end
    end

    // Stage one feeds both modes, stage two finishes tanh
    always_ff @(posedge clk) begin
        if (in_valid) begin
            relu_q    <= relu_d;
            slope_x_q <= slope_x_d;
            icpt_q    <= icpt_d;
        end
        if (valid_s1) begin
            for (int i = 0; i < act_pkg::LANES; i++) begin
                tanh_q[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] <=
                    slope_x_q[i*act_pkg::DWIDTH +: act_pkg::DWIDTH] +
                    icpt_q[i*act_pkg::DWIDTH +: act_pkg::DWIDTH];
            end
        end
    end

    // Bypass is combinational when the block is disabled
    always_comb begin
        if (!act_enable) begin
            out_valid = in_valid;
            out_data  = in_data;
        end else if (act_type == act_pkg::ACT_TANH) begin
            out_valid = valid_s2;
            out_data  = tanh_q;
        end else begin
            out_valid = valid_s1;
            out_data  = relu_q;
        end
    end

endmodule

`default_nettype wire

// File: act_engine.sv
`default_nettype none
`timescale 1ns/1ps

module act_engine (
    input  logic                       clk,
    input  logic                       rst,

    // Run control
    input  logic                       start,
    input  logic [act_pkg::ADDR_W-1:0] src_addr,
    input  logic [act_pkg::ADDR_W-1:0] dst_addr,
    input  logic [act_pkg::CNT_W-1:0]  count,
    input  logic                       act_type_in,
    input  logic                       act_enable_in,
    output logic                       busy,
    output logic                       done,

    // Scratchpad port through the arbiter
    output logic                       eng_req,
    output logic                       eng_we,
    output logic [act_pkg::ADDR_W-1:0] eng_addr,
    output logic [act_pkg::WORD_W-1:0] eng_wdata,
    input  logic                       eng_gnt,
    input  logic                       eng_rvalid,
    input  logic [act_pkg::WORD_W-1:0] eng_rdata,

    // Activation block
    output logic                       act_type,
    output logic                       act_enable,
    output logic                       in_valid,
    output logic [act_pkg::WORD_W-1:0] in_data,
    input  logic                       out_valid,
    input  logic [act_pkg::WORD_W-1:0] out_data
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_READ      = 3'd1;
    localparam logic [2:0] S_WAIT_DATA = 3'd2;
    localparam logic [2:0] S_WAIT_ACT  = 3'd3;
    localparam logic [2:0] S_WRITE     = 3'd4;

    logic [2:0]                 state;
    logic [act_pkg::ADDR_W-1:0] rd_ptr;
    logic [act_pkg::ADDR_W-1:0] wr_ptr;
    logic [act_pkg::CNT_W-1:0]  remaining;
    logic [act_pkg::WORD_W-1:0] hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            done       <= 1'b0;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            remaining  <= '0;
            act_type   <= act_pkg::ACT_RELU;
            act_enable <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    // A zero count has nothing to do
                    if (start && count != '0) begin
                        rd_ptr     <= src_addr;
                        wr_ptr     <= dst_addr;
                        remaining  <= count;
                        act_type   <= act_type_in;
                        act_enable <= act_enable_in;
                        state      <= S_READ;
                    end
                end
                S_READ: begin
                    if (eng_gnt) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= S_WAIT_DATA;
                    end
                end
                S_WAIT_DATA: begin
                    // Bypass returns the result in the same cycle
                    if (eng_rvalid) begin
                        state <= out_valid ? S_WRITE : S_WAIT_ACT;
                    end
                end
                S_WAIT_ACT: begin
                    if (out_valid) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (eng_gnt) begin
                        wr_ptr    <= wr_ptr + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == 1) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result waits here until the write is granted
    always_ff @(posedge clk) begin
        if (out_valid) begin
            hold <= out_data;
        end
    end

    assign busy = (state != S_IDLE);

    assign eng_req   = (state == S_READ) || (state == S_WRITE);
    assign eng_we    = (state == S_WRITE);
    assign eng_addr  = eng_we ? wr_ptr : rd_ptr;
    assign eng_wdata = hold;

    assign in_valid = (state == S_WAIT_DATA) && eng_rvalid;
    assign in_data  = eng_rdata;

endmodule

`default_nettype wire

// File: act_top.sv
`default_nettype none
`timescale 1ns/1ps

module act_top (
    input  logic                       clk,
    input  logic                       rst,

    // Host port
    input  logic                       host_req,
    input  logic                       host_we,
    input  logic [act_pkg::ADDR_W-1:0] host_addr,
    input  logic [act_pkg::WORD_W-1:0] host_wdata,
    output logic                       host_gnt,
    output logic                       host_rvalid,
    output logic [act_pkg::WORD_W-1:0] host_rdata,

    // Engine control
    input  logic                       start,
    input  logic [act_pkg::ADDR_W-1:0] src_addr,
    input  logic [act_pkg::ADDR_W-1:0] dst_addr,
    input  logic [act_pkg::CNT_W-1:0]  count,
    input  logic                       act_type,
    input  logic                       act_enable,
    output logic                       busy,
    output logic                       done
);

    logic                       eng_req;
    logic                       eng_we;
    logic [act_pkg::ADDR_W-1:0] eng_addr;
    logic [act_pkg::WORD_W-1:0] eng_wdata;
    logic                       eng_gnt;
    logic                       eng_rvalid;
    logic [act_pkg::WORD_W-1:0] eng_rdata;

    logic                       mem_en;
    logic                       mem_we;
    logic [act_pkg::ADDR_W-1:0] mem_addr;
    logic [act_pkg::WORD_W-1:0] mem_wdata;
    logic [act_pkg::WORD_W-1:0] mem_rdata;

    // Run settings held by the engine
    logic                       run_type;
    logic                       run_enable;
    logic                       in_valid;
    logic [act_pkg::WORD_W-1:0] in_data;
    logic                       out_valid;
    logic [act_pkg::WORD_W-1:0] out_data;

    act_scratchpad u_scratchpad (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    act_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .eng_req     (eng_req),
        .eng_we      (eng_we),
        .eng_addr    (eng_addr),
        .eng_wdata   (eng_wdata),
        .eng_gnt     (eng_gnt),
        .eng_rvalid  (eng_rvalid),
        .eng_rdata   (eng_rdata),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    act_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .src_addr      (src_addr),
        .dst_addr      (dst_addr),
        .count         (count),
        .act_type_in   (act_type),
        .act_enable_in (act_enable),
        .busy          (busy),
        .done          (done),
        .eng_req       (eng_req),
        .eng_we        (eng_we),
        .eng_addr      (eng_addr),
        .eng_wdata     (eng_wdata),
        .eng_gnt       (eng_gnt),
        .eng_rvalid    (eng_rvalid),
        .eng_rdata     (eng_rdata),
        .act_type      (run_type),
        .act_enable    (run_enable),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    activation u_activation (
        .clk        (clk),
        .rst        (rst),
        .act_type   (run_type),
        .act_enable (run_enable),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

`default_nettype wire

// File: act_sva.sv
`timescale 1ns/1ps
`default_nettype none

module act_sva (
    input logic clk,
    input logic rst,
    input logic host_req,
    input logic host_we,
    input logic host_gnt,
    input logic host_rvalid,
    input logic eng_req,
    input logic eng_we,
    input logic eng_gnt,
    input logic eng_rvalid,
    input logic busy,
    input logic done
);

    // Only one side reaches the scratchpad per cycle
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({host_gnt, eng_gnt}))
        else $error("host and engine granted in the same cycle");

    grant_needs_req: assert property (@(posedge clk) disable iff (rst)
        (!host_gnt || host_req) && (!eng_gnt || eng_req))
        else $error("grant issued without a request");

    // Read data comes back exactly one cycle after its own grant
    host_rvalid_timing: assert property (@(posedge clk) disable iff (rst)
        host_rvalid == $past(host_gnt && !host_we))
        else $error("host rvalid does not follow a host read grant");

    eng_rvalid_timing: assert property (@(posedge clk) disable iff (rst)
        eng_rvalid == $past(eng_gnt && !eng_we))
        else $error("engine rvalid does not follow an engine read grant");

    done_in_run: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy))
        else $error("done raised outside a run");

endmodule

bind act_top act_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .eng_req     (eng_req),
    .eng_we      (eng_we),
    .eng_gnt     (eng_gnt),
    .eng_rvalid  (eng_rvalid),
    .busy        (busy),
    .done        (done)
);

`default_nettype wire

// File: act_tb.sv
`timescale 1ns/1ps
`default_nettype none

module act_tb;

    logic                       clk;
    logic                       rst;
    logic                       host_req;
    logic                       host_we;
    logic [act_pkg::ADDR_W-1:0] host_addr;
    logic [act_pkg::WORD_W-1:0] host_wdata;
    logic                       host_gnt;
    logic                       host_rvalid;
    logic [act_pkg::WORD_W-1:0] host_rdata;
    logic                       start;
    logic [act_pkg::ADDR_W-1:0] src_addr;
    logic [act_pkg::ADDR_W-1:0] dst_addr;
    logic [act_pkg::CNT_W-1:0]  count;
    logic                       act_type;
    logic                       act_enable;
    logic                       busy;
    logic                       done;

    // Known scratchpad words, used to check host reads during a run
    logic [act_pkg::WORD_W-1:0] shadow [act_pkg::DEPTH];
    logic                       shadow_ok [act_pkg::DEPTH];

    logic [31:0]                rand_state;
    logic [8*24-1:0]            test_name;
    logic                       test_open;
    logic                       run_pending;
    logic [act_pkg::ADDR_W-1:0] run_src;
    logic [act_pkg::CNT_W-1:0]  run_cnt;
    int                         n_lines = 0;
    int                         n_tests = 0;
    int                         n_failed_tests = 0;
    int                         n_checks = 0;
    int                         n_errors = 0;
    int                         test_errors = 0;
    int                         runs_started = 0;
    int                         runs_done = 0;

    act_top uut (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .start       (start),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .count       (count),
        .act_type    (act_type),
        .act_enable  (act_enable),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && done) begin
            runs_done <= runs_done + 1;
        end
    end

    // Budget of 200 cycles per stimulus line
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", n_lines * 200);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(
        input logic [act_pkg::ADDR_W-1:0] a,
        input logic [act_pkg::WORD_W-1:0] expected,
        input logic [act_pkg::WORD_W-1:0] actual
    );
        $display("[FAIL] %0s: word %02h expected %08h actual %08h",
                 test_name, a, expected, actual);
        n_errors++;
        test_errors++;
    endtask

    // One host access, held until granted
    task automatic access_word(
        input  logic                       we,
        input  logic [act_pkg::ADDR_W-1:0] a,
        input  logic [act_pkg::WORD_W-1:0] wd,
        output logic [act_pkg::WORD_W-1:0] rd
    );
        rd = '0;
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = a;
        host_wdata = wd;
        @(posedge clk);
        while (!host_gnt) begin
            @(posedge clk);
        end
        @(negedge clk);
        host_req = 1'b0;
        host_we  = 1'b0;
        if (!we) begin
            while (!host_rvalid) begin
                @(negedge clk);
            end
            rd = host_rdata;
        end
    endtask

    task automatic start_run(
        input logic [act_pkg::ADDR_W-1:0] s,
        input logic [act_pkg::ADDR_W-1:0] d,
        input logic [act_pkg::CNT_W-1:0]  n,
        input logic                       kind,
        input logic                       enable
    );
        @(negedge clk);
        // The engine takes the command only when no run is in progress
        if (!run_pending && n != '0) begin
            runs_started++;
            run_pending = 1'b1;
            run_src     = s;
            run_cnt     = n;
        end
        start      = 1'b1;
        src_addr   = s;
        dst_addr   = d;
        count      = n;
        act_type   = kind;
        act_enable = enable;
        @(negedge clk);
        start = 1'b0;
    endtask

    // Wait for the engine, with random host reads of the source region
    task automatic finish_run;
        logic [7:0]                 offset;
        logic [act_pkg::ADDR_W-1:0] a;
        logic [act_pkg::WORD_W-1:0] d;
        if (run_pending) begin
            @(negedge clk);
            while (busy) begin
                rand_state = next_random(rand_state);
                if (!rand_state[31]) begin
                    offset = rand_state[23:16] % run_cnt;
                    a      = run_src + offset[act_pkg::ADDR_W-1:0];
                    access_word(1'b0, a, '0, d);
                    n_checks++;
                    if (shadow_ok[a] && d !== shadow[a]) begin
                        report_mismatch(a, shadow[a], d);
                    end
                end else begin
                    @(negedge clk);
                end
            end
            @(negedge clk);
            run_pending = 1'b0;
            n_checks++;
            if (runs_done != runs_started) begin
                $display("Engine gave %0d done pulses for %0d accepted starts in %0s",
                         runs_done, runs_started, test_name);
                n_errors++;
                test_errors++;
            end
        end
    endtask

    task automatic close_test;
        if (test_open) begin
            n_tests++;
            if (test_errors == 0) begin
                $display("Test %0s passed", test_name);
            end else begin
                n_failed_tests++;
                $display("Test %0s failed with %0d errors", test_name, test_errors);
            end
        end
    endtask

    task automatic run_stimulus(input int fd);
        int                         c;
        int                         r;
        logic [act_pkg::ADDR_W-1:0] a1;
        logic [act_pkg::ADDR_W-1:0] a2;
        logic [act_pkg::CNT_W-1:0]  n;
        logic                       kind;
        logic                       enable;
        logic [act_pkg::WORD_W-1:0] w;
        logic [act_pkg::WORD_W-1:0] got;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == int'("#")) begin
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c == int'("N")) begin
                finish_run();
                close_test();
                r = $fscanf(fd, "%s", test_name);
                test_open   = 1'b1;
                test_errors = 0;
            end else if (c == int'("W")) begin
                r = $fscanf(fd, "%h %h", a1, w);
                finish_run();
                access_word(1'b1, a1, w, got);
                shadow[a1]    = w;
                shadow_ok[a1] = 1'b1;
            end else if (c == int'("R")) begin
                // No wait here, so a second start can land while busy
                r = $fscanf(fd, "%h %h %h %h %h", a1, a2, n, kind, enable);
                start_run(a1, a2, n, kind, enable);
            end else if (c == int'("E")) begin
                r = $fscanf(fd, "%h %h", a1, w);
                finish_run();
                access_word(1'b0, a1, '0, got);
                n_checks++;
                if (got !== w) begin
                    report_mismatch(a1, w, got);
                end
                shadow[a1]    = w;
                shadow_ok[a1] = 1'b1;
            end
            c = $fgetc(fd);
        end
        finish_run();
        close_test();
    endtask

    initial begin
        int fd;
        int c;
        int lines;
        rst         = 1'b1;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        start       = 1'b0;
        src_addr    = '0;
        dst_addr    = '0;
        count       = '0;
        act_type    = 1'b0;
        act_enable  = 1'b0;
        rand_state  = 32'h26f45f5f;
        test_name   = '0;
        test_open   = 1'b0;
        run_pending = 1'b0;
        run_src     = '0;
        run_cnt     = '0;
        lines       = 0;
        for (int i = 0; i < act_pkg::DEPTH; i++) begin
            shadow[i]    = '0;
            shadow_ok[i] = 1'b0;
        end
        fd = $fopen("act_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file act_stim.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10) begin
                    lines++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            n_lines = lines + 1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            fd = $fopen("act_stim.txt", "r");
            run_stimulus(fd);
            $fclose(fd);
            $display("%0d tests: %0d passed, %0d failed; %0d checks, %0d errors",
                     n_tests, n_tests - n_failed_tests, n_failed_tests, n_checks, n_errors);
            if (n_errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: act_stim.txt
# N name | W addr word (host write) | E addr word (host read and compare)
# R src dst count type enable, all hex; type 0 is ReLU, 1 is tanh
N host_rw
W 00 a5a5a5a5
W 3f 5a0f3c96
E 00 a5a5a5a5
E 3f 5a0f3c96
N relu
W 01 807f01ff
W 02 00c840e0
R 01 10 2 0 1
E 10 007f0100
E 11 00004000
N tanh
W 20 27595a7f
W 21 101b1c26
W 22 ff00010f
W 23 e4e5f0f1
W 24 a6a7d9da
W 25 14c04080
R 20 30 6 1 1
E 30 63637f7f
E 31 4263667a
E 32 fc00043c
E 33 9a9dbec4
E 34 819d9d86
E 35 4e9d6381
N bypass
R 01 12 2 0 0
E 12 807f01ff
E 13 00c840e0
N contention
R 20 38 6 1 1
E 38 63637f7f
E 39 4263667a
E 3a fc00043c
E 3b 9a9dbec4
E 3c 819d9d86
E 3d 4e9d6381
N busy_start
W 3e deadbeef
R 01 16 2 1 1
R 20 3e 1 0 0
E 16 817f04fc
E 17 009d6392
E 3e deadbeef

// File: verilog.f
act_pkg.sv
act_scratchpad.sv
act_arbiter.sv
activation.sv
act_engine.sv
act_top.sv
act_sva.sv
act_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= act_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
